//--- aluPath.sv
`timescale 1ns/1ps
`default_nettype none

module aluPath import srcPkg::*; (
    input  wire       clock,
    input  wire       rst,
    input  wire       yLoad,
    input  wire       zLoad,
    input  wire       pcIncrement,
    input  wire wordT bus,
    output wordT      zValue
);

    wordT yQ;                            // left operand.
    wordT zQ;                            // result.
    wordT sum;

    // increment uses the bus alone, add uses y and the bus.
    assign sum = pcIncrement ? (bus + wordT'(1)) : (yQ + bus); // wraps mod 2^32.

    always_ff @(posedge clock) begin
        if (rst) begin
            yQ <= '0;
            zQ <= '0;
        end else begin
            if (yLoad) begin
                yQ <= bus;
            end
            if (zLoad) begin
                zQ <= sum;
            end
        end
    end

    assign zValue = zQ;

    // increment only means something while z captures.
    incWithLoad: assert property (@(posedge clock) disable iff (rst)
        pcIncrement |-> zLoad);

endmodule

`default_nettype wire

//--- busSelect.sv
`timescale 1ns/1ps
`default_nettype none

module busSelect import srcPkg::*; (
    input  wire       clock,
    input  wire       rst,
    input  wire       pcOut,
    input  wire       mdrOut,
    input  wire       regOut,
    input  wire       zOut,
    input  wire       constOut,
    input  wire       inPortOut,
    input  wire       mdrLoad,
    input  wire       outPortLoad,
    input  wire wordT pcValue,
    input  wire wordT regData,
    input  wire wordT zValue,
    input  wire wordT constValue,
    input  wire wordT memData,
    input  wire wordT inPortData,
    output wordT      bus,
    output wordT      outPortData,
    output logic      outPortStrobe
);

    wordT mdrQ;                          // memory data register.
    wordT outPortQ;                      // output port register.
    logic strobeQ;                       // new output value marker.

    always_comb begin
        if (pcOut)          bus = pcValue;
        else if (mdrOut)    bus = mdrQ;
        else if (regOut)    bus = regData;
        else if (zOut)      bus = zValue;
        else if (constOut)  bus = constValue;
        else if (inPortOut) bus = inPortData;
        else                bus = '0;  // idle bus reads zero.
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mdrQ     <= '0;
            outPortQ <= '0;
            strobeQ  <= 1'b0;
        end else begin
            if (mdrLoad) begin
                mdrQ <= memData;           // end of memWait2.
            end
            if (outPortLoad) begin
                outPortQ <= bus;
            end
            strobeQ <= outPortLoad;        // marks the cycle the new value shows.
        end
    end

    assign outPortData   = outPortQ;
    assign outPortStrobe = strobeQ;

    driveOneHot: assert property (@(posedge clock) disable iff (rst)
        $onehot0({pcOut, mdrOut, regOut, zOut, constOut, inPortOut}));

endmodule

`default_nettype wire

//--- controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer import srcPkg::*; (
    input  wire            clock,
    input  wire            rst,
    input  wire wordT      bus,
    output logic           pcOut,
    output logic           pcIncrement,
    output logic           pcLoad,
    output logic           marLoad,
    output logic           memRead,
    output logic           mdrLoad,
    output logic           mdrOut,
    output logic           regIn,
    output logic           regOut,
    output logic           yLoad,
    output logic           zLoad,
    output logic           zOut,
    output logic           constOut,
    output logic           inPortOut,
    output logic           outPortLoad,
    output regIndexT       regIndex,
    output wordT           constValue
);

    seqStateT stateQ;                    // current step.
    seqStateT stateNext;
    wordT     irQ;                       // instruction register.
    logic     running;                   // low in the first cycle after reset.
    opcodeT   opcode;
    regIndexT raField;
    regIndexT rbField;

    assign opcode     = opcodeT'(irQ[opcodeMsb:opcodeLsb]);
    assign raField    = irQ[raMsb:raLsb];
    assign rbField    = irQ[rbMsb:rbLsb];
    assign constValue = {{(31 - constMsb){irQ[constMsb]}}, irQ[constMsb:0]}; // sign extend.

    always_ff @(posedge clock) begin
        if (rst) begin
            stateQ  <= T0;
            running <= 1'b0;
            irQ     <= '0;                 // decodes as nop.
        end else begin
            stateQ  <= stateNext;
            running <= 1'b1;
            if (stateQ == T2) begin
                irQ <= bus;                // mdr is on the bus here.
            end
        end
    end

    always_comb begin
        case (stateQ)
            T0:       stateNext = running ? T1 : T0; // idle one cycle out of reset.
            T1:       stateNext = memWait1;
            memWait1: stateNext = memWait2;
            memWait2: stateNext = T2;
            T2:       stateNext = T3;
            T3:       stateNext = T4;
            T4:       stateNext = T5;
            default:  stateNext = T0;      // T5 wraps to the next fetch.
        endcase
    end

    always_comb begin
        pcOut       = 1'b0;
        pcIncrement = 1'b0;
        pcLoad      = 1'b0;
        marLoad     = 1'b0;
        memRead     = 1'b0;
        mdrLoad     = 1'b0;
        mdrOut      = 1'b0;
        regIn       = 1'b0;
        regOut      = 1'b0;
        yLoad       = 1'b0;
        zLoad       = 1'b0;
        zOut        = 1'b0;
        constOut    = 1'b0;
        inPortOut   = 1'b0;
        outPortLoad = 1'b0;
        regIndex    = raField;             // ra unless told otherwise.
        case (stateQ)
            T0: begin
                if (running) begin
                    pcOut       = 1'b1;    // pc to bus.
                    marLoad     = 1'b1;    // fetch address.
                    memRead     = 1'b1;    // start the read.
                    pcIncrement = 1'b1;    // z gets pc + 1.
                    zLoad       = 1'b1;
                end
            end
            T1: begin
                zOut   = 1'b1;             // pc + 1 back to pc.
                pcLoad = 1'b1;
            end
            memWait2: mdrLoad = 1'b1;      // memory word is valid now.
            T2:       mdrOut  = 1'b1;      // ir loads from the bus.
            T3: begin
                case (opcode)
                    opAddi: begin
                        regOut   = 1'b1;   // rb to y.
                        regIndex = rbField;
                        yLoad    = 1'b1;
                    end
                    opJal: begin
                        pcOut    = 1'b1;   // return address to r15.
                        regIn    = 1'b1;
                        regIndex = linkReg;
                    end
                    opIn: begin
                        inPortOut = 1'b1;  // input port to ra.
                        regIn     = 1'b1;
                    end
                    opOut: begin
                        regOut      = 1'b1; // ra to output port.
                        outPortLoad = 1'b1;
                    end
                    default: ;             // jr and nop idle here.
                endcase
            end
            T4: begin
                case (opcode)
                    opAddi: begin
                        constOut = 1'b1;   // z = y + constant.
                        zLoad    = 1'b1;
                    end
                    opJr, opJal: begin
                        regOut = 1'b1;     // jump target ra.
                        pcLoad = 1'b1;
                    end
                    default: ;
                endcase
            end
            T5: begin
                if (opcode == opAddi) begin
                    zOut  = 1'b1;          // sum to ra.
                    regIn = 1'b1;
                end
            end
            default: ;                     // memWait1 only waits.
        endcase
    end

    stateLegal: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(stateQ) && (stateQ inside {T0, T1, memWait1, memWait2, T2, T3, T4, T5}));

endmodule

`default_nettype wire

//--- coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb import srcPkg::*; ();

    localparam int memWords       = 64;    // program memory depth.
    localparam int addrBits       = $clog2(memWords);
    localparam int clockHalf      = 10;    // 20 ns period.
    localparam int driveSkew      = 1;     // inputs change this long after the edge.
    localparam int skipTarget     = 22;    // jr lands here, past two skipped words.
    localparam int subroutineAddr = 27;    // out r15, jr r15.

    logic clock;
    logic rst;
    wordT memData;
    wordT inPortData;
    wordT memAddr;
    logic memRead;
    wordT outPortData;
    logic outPortStrobe;

    wordT   progMem [memWords];            // program image.
    int     progLength;
    int     finalOutAddr;                  // the run ends on this out.
    integer seed;
    wordT   modelRegs [regCount];          // reference register state.
    wordT   modelPc;                       // address of the next fetch.
    wordT   expectOut [$];                 // output values still to appear.
    wordT   expectAddr;
    wordT   dataWord;                      // word the memory drives next.
    wordT   inValue;                       // input port value for this instruction.
    logic   fetchPending;
    logic   finalStepped;
    logic   runDone;
    int     cycleCount;
    int     timeoutLimit;
    int     cyclesSinceRead;
    int     readsSeen;

    miniSrcCore DUT (
        .clock         (clock),
        .rst           (rst),
        .memData       (memData),
        .inPortData    (inPortData),
        .memAddr       (memAddr),
        .memRead       (memRead),
        .outPortData   (outPortData),
        .outPortStrobe (outPortStrobe)
    );

    task automatic stopOnError(string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, wordT expected, wordT actual);
        assert (actual === expected)
            else stopOnError($sformatf("FAIL at %0t ns: %s expected %h, got %h",
                                       $time, name, expected, actual));
    endtask

    function automatic wordT makeInstr(logic [4:0] op, regIndexT ra, regIndexT rb,
                                       logic [constMsb:0] imm);
        wordT w;
        w                      = '0;
        w[opcodeMsb:opcodeLsb] = op;
        w[raMsb:raLsb]         = ra;
        w[rbMsb:rbLsb]         = rb;
        w[constMsb:0]          = imm;
        return w;
    endfunction

    // unused words decode as an unknown opcode.
    function automatic wordT fillWord(wordT addr);
        return {5'b11111, addr[26:0] ^ {22'd0, addr[31:27]}};
    endfunction

    function automatic wordT readWord(wordT addr);
        if (addr < wordT'(memWords)) begin
            return progMem[addr[addrBits-1:0]];
        end else begin
            return fillWord(addr);
        end
    endfunction

    task automatic appendWord(wordT w);
        progMem[progLength] = w;
        progLength          = progLength + 1;
    endtask

    task automatic buildProgram();
        wordT              r;
        logic [constMsb:0] imm;
        for (int a = 0; a < memWords; a++) begin
            progMem[a] = fillWord(wordT'(a));
        end
        progLength = 0;
        appendWord(makeInstr(opIn, 4'd1, 4'd0, '0));   // r1 from the input port.
        appendWord(makeInstr(opOut, 4'd1, 4'd0, '0));
        for (int i = 0; i < 12; i++) begin
            r   = $random(seed);
            imm = {i[1], r[17:0]};                     // sign flips every other step.
            if (i[0] == 1'b0) begin
                appendWord(makeInstr(opAddi, 4'd3, (i == 0) ? 4'd1 : 4'd3, imm));
            end else begin
                appendWord(makeInstr(opAddi, 4'd4, (i == 1) ? 4'd0 : 4'd4, imm));
            end
        end
        appendWord(makeInstr(opOut, 4'd3, 4'd0, '0));  // both sums.
        appendWord(makeInstr(opOut, 4'd4, 4'd0, '0));
        appendWord(makeInstr(opAddi, 4'd2, 4'd0, 19'(subroutineAddr)));
        appendWord(makeInstr(opJal, 4'd2, 4'd0, '0));
        appendWord(makeInstr(opAddi, 4'd5, 4'd0, 19'(skipTarget)));
        appendWord(makeInstr(opJr, 4'd5, 4'd0, '0));
        appendWord(makeInstr(opOut, 4'd1, 4'd0, '0));  // skipped.
        appendWord(makeInstr(opIn, 4'd3, 4'd0, '0));   // skipped.
        appendWord(makeInstr(5'b00000, 4'd3, 4'd1, 19'h12345));
        appendWord(makeInstr(5'b11111, 4'd4, 4'd3, 19'h7ffff));
        appendWord(makeInstr(5'b01101, 4'd3, 4'd3, 19'h40000));
        appendWord(makeInstr(opNop, 4'd3, 4'd4, 19'h00001));
        finalOutAddr = progLength;
        appendWord(makeInstr(opOut, 4'd3, 4'd0, '0));
        appendWord(makeInstr(opOut, linkReg, 4'd0, '0)); // subroutine.
        appendWord(makeInstr(opJr, linkReg, 4'd0, '0));
        assert (finalOutAddr + 1 == subroutineAddr && skipTarget == finalOutAddr - 4)
            else stopOnError("program layout does not match the jump targets");
    endtask

    // one instruction of the reference ISA, run at its fetch.
    task automatic stepModel();
        wordT                     w;
        wordT                     target;
        regIndexT                 ra;
        regIndexT                 rb;
        logic signed [constMsb:0] imm;
        int                       immValue;
        w        = readWord(modelPc);
        ra       = w[raMsb:raLsb];
        rb       = w[rbMsb:rbLsb];
        imm      = w[constMsb:0];
        immValue = int'(imm);
        target   = modelPc + 32'd1;
        case (opcodeT'(w[opcodeMsb:opcodeLsb]))
            opAddi: modelRegs[ra] = modelRegs[rb] + wordT'(immValue);
            opJr:   target = modelRegs[ra];
            opJal: begin
                target             = modelRegs[ra];
                modelRegs[linkReg] = modelPc + 32'd1; // return address.
            end
            opIn:   modelRegs[ra] = inValue;
            opOut:  expectOut.push_back(modelRegs[ra]);
            default: ;                                // nop and unknown opcodes.
        endcase
        if (modelPc == wordT'(finalOutAddr)) begin
            finalStepped = 1'b1;
        end
        modelPc = target;
    endtask

    initial begin
        clock = 1'b0;
        forever #clockHalf clock = ~clock;
    end

    initial begin
        seed            = 32'h40ec5785;
        rst             = 1'b1;
        memData         = '0;
        inPortData      = '0;
        dataWord        = '0;
        inValue         = '0;
        modelPc         = resetPc;
        expectAddr      = '0;
        fetchPending    = 1'b0;
        finalStepped    = 1'b0;
        runDone         = 1'b0;
        cycleCount      = 0;
        cyclesSinceRead = 0;
        readsSeen       = 0;
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        buildProgram();
        timeoutLimit = 8 * progLength + 40;
        repeat (2) @(posedge clock);
        #driveSkew;
        rst = 1'b0;
        wait (runDone);
        $display("** PASS **");
        $finish;
    end

    // memory and input port, driven just after the edge.
    always @(posedge clock) begin
        #driveSkew;
        memData    = dataWord;
        inPortData = inValue;
    end

    // mid-cycle monitor, model and memory lookup.
    always @(negedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            stopOnError($sformatf("timeout: the program did not finish within %0d cycles",
                                  timeoutLimit));
        end
        if (!rst) begin
            if (fetchPending) begin
                checkValue("memAddr", expectAddr, memAddr);
                dataWord     = readWord(memAddr); // shows up one cycle after the read.
                fetchPending = 1'b0;
            end
            if (outPortStrobe) begin
                if (expectOut.size() == 0) begin
                    stopOnError("output port strobed without a pending out instruction");
                end else begin
                    checkValue("outPortData", expectOut.pop_front(), outPortData);
                end
                if (finalStepped && expectOut.size() == 0) begin
                    runDone = 1'b1;
                end
            end
            cyclesSinceRead = cyclesSinceRead + 1;
            if (memRead) begin
                if (readsSeen > 0) begin
                    assert (cyclesSinceRead == 8)
                        else stopOnError($sformatf("memRead came %0d cycles after the last one",
                                                   cyclesSinceRead));
                end
                readsSeen       = readsSeen + 1;
                cyclesSinceRead = 0;
                expectAddr      = modelPc;
                fetchPending    = 1'b1;
                inValue         = $random(seed); // held for the whole instruction.
                stepModel();
            end
        end
    end

    resetQuiet: assert property (@(posedge clock) rst |=> (!memRead && !outPortStrobe))
        else stopOnError("memRead or outPortStrobe was high right after a reset cycle");

    firstFetch: assert property (@(posedge clock)
        $fell(rst) |-> (!memRead && !outPortStrobe) ##1 memRead ##1 (memAddr == resetPc))
        else stopOnError("the first fetch after reset missed its cycle or its address");

    readPeriod: assert property (@(posedge clock) disable iff (rst)
        memRead |-> ##8 memRead)
        else stopOnError("memRead did not come back eight cycles after the last pulse");

    strobeSingle: assert property (@(posedge clock) disable iff (rst)
        outPortStrobe |=> !outPortStrobe)
        else stopOnError("outPortStrobe stayed high for more than one cycle");

endmodule

`default_nettype wire

//--- miniSrcCore.sv
`timescale 1ns/1ps
`default_nettype none

module miniSrcCore import srcPkg::*; (
    input  wire       clock,
    input  wire       rst,
    input  wire wordT memData,
    input  wire wordT inPortData,
    output wordT      memAddr,
    output logic      memRead,
    output wordT      outPortData,
    output logic      outPortStrobe
);

    wordT     bus;                       // single internal bus.
    logic     pcOut;
    logic     pcIncrement;
    logic     pcLoad;
    logic     marLoad;
    logic     mdrLoad;
    logic     mdrOut;
    logic     regIn;
    logic     regOut;
    logic     yLoad;
    logic     zLoad;
    logic     zOut;
    logic     constOut;
    logic     inPortOut;
    logic     outPortLoad;
    regIndexT regIndex;
    wordT     constValue;
    wordT     regData;
    wordT     pcValue;
    wordT     zValue;

    controlSequencer sequencer (
        .clock       (clock),
        .rst         (rst),
        .bus         (bus),
        .pcOut       (pcOut),
        .pcIncrement (pcIncrement),
        .pcLoad      (pcLoad),
        .marLoad     (marLoad),
        .memRead     (memRead),
        .mdrLoad     (mdrLoad),
        .mdrOut      (mdrOut),
        .regIn       (regIn),
        .regOut      (regOut),
        .yLoad       (yLoad),
        .zLoad       (zLoad),
        .zOut        (zOut),
        .constOut    (constOut),
        .inPortOut   (inPortOut),
        .outPortLoad (outPortLoad),
        .regIndex    (regIndex),
        .constValue  (constValue)
    );

    registerFile regs (
        .clock    (clock),
        .rst      (rst),
        .regIn    (regIn),
        .regOut   (regOut),
        .regIndex (regIndex),
        .bus      (bus),
        .regData  (regData)
    );

    aluPath alu (
        .clock       (clock),
        .rst         (rst),
        .yLoad       (yLoad),
        .zLoad       (zLoad),
        .pcIncrement (pcIncrement),
        .bus         (bus),
        .zValue      (zValue)
    );

    programCounter pc (
        .clock   (clock),
        .rst     (rst),
        .pcLoad  (pcLoad),
        .marLoad (marLoad),
        .bus     (bus),
        .pcValue (pcValue),
        .memAddr (memAddr)
    );

    busSelect busMux (
        .clock         (clock),
        .rst           (rst),
        .pcOut         (pcOut),
        .mdrOut        (mdrOut),
        .regOut        (regOut),
        .zOut          (zOut),
        .constOut      (constOut),
        .inPortOut     (inPortOut),
        .mdrLoad       (mdrLoad),
        .outPortLoad   (outPortLoad),
        .pcValue       (pcValue),
        .regData       (regData),
        .zValue        (zValue),
        .constValue    (constValue),
        .memData       (memData),
        .inPortData    (inPortData),
        .bus           (bus),
        .outPortData   (outPortData),
        .outPortStrobe (outPortStrobe)
    );

endmodule

`default_nettype wire

//--- programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter import srcPkg::*; (
    input  wire       clock,
    input  wire       rst,
    input  wire       pcLoad,
    input  wire       marLoad,
    input  wire wordT bus,
    output wordT      pcValue,
    output wordT      memAddr
);

    wordT pcQ;                           // address of the next fetch.
    wordT marQ;                          // memory address register.

    always_ff @(posedge clock) begin
        if (rst) begin
            pcQ  <= resetPc;
            marQ <= '0;
        end else begin
            if (pcLoad) begin
                pcQ <= bus;                // pc + 1 in T1, target in T4.
            end
            if (marLoad) begin
                marQ <= bus;               // pc in T0.
            end
        end
    end

    assign pcValue = pcQ;
    assign memAddr = marQ;                 // straight to the memory port.

    // pc and mar load in different steps of the fetch.
    loadExclusive: assert property (@(posedge clock) disable iff (rst)
        !(pcLoad && marLoad));

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import srcPkg::*; (
    input  wire           clock,
    input  wire           rst,
    input  wire           regIn,
    input  wire           regOut,
    input  wire regIndexT regIndex,
    input  wire wordT     bus,
    output wordT          regData
);

    wordT regs [regCount];               // r0 is an ordinary register too.

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;             // all registers clear.
            end
        end else if (regIn) begin
            regs[regIndex] <= bus;         // single write port.
        end
    end

    // read port, gated onto the bus by regOut in busSelect.
    assign regData = regs[regIndex];

    // one index serves both ports, so a read and a write never share a cycle.
    portExclusive: assert property (@(posedge clock) disable iff (rst)
        !(regIn && regOut));

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module coreTb -o coreTb \
    && ./obj_dir/coreTb | tee /dev/stderr | grep -F -- '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- srcPkg.sv
`default_nettype none

package srcPkg;

    typedef logic [31:0] wordT;          // bus, register, port and memory word.
    typedef logic [3:0]  regIndexT;      // general register number.

    // opcodes not listed here run as nop.
    typedef enum logic [4:0] {
        opNop  = 5'b11010,               // no operation.
        opAddi = 5'b01100,               // ra = rb + sign-extended constant.
        opJr   = 5'b10100,               // pc = ra.
        opJal  = 5'b10101,               // r15 = pc, pc = ra.
        opIn   = 5'b10110,               // ra = input port.
        opOut  = 5'b10111                // output port = ra.
    } opcodeT;

    // one clock per state, eight per instruction.
    typedef enum logic [2:0] {
        T0       = 3'd0,                 // pc to mar, start read.
        T1       = 3'd1,                 // pc takes pc + 1.
        memWait1 = 3'd2,                 // first memory wait.
        memWait2 = 3'd3,                 // mdr captures memory word.
        T2       = 3'd4,                 // mdr to ir.
        T3       = 3'd5,                 // execute step one.
        T4       = 3'd6,                 // execute step two.
        T5       = 3'd7                  // execute step three.
    } seqStateT;

    localparam int regCount  = 16;       // general registers.

    localparam int opcodeMsb = 31;       // opcode field.
    localparam int opcodeLsb = 27;
    localparam int raMsb     = 26;       // ra field.
    localparam int raLsb     = 23;
    localparam int rbMsb     = 22;       // rb field.
    localparam int rbLsb     = 19;
    localparam int constMsb  = 18;       // immediate is bits 18..0, signed.

    localparam regIndexT linkReg = 4'd15;        // jal return address.
    localparam wordT     resetPc = 32'h0000_0000; // first fetch address.

endpackage

`default_nettype wire

//--- vlog.f
srcPkg.sv
registerFile.sv
programCounter.sv
aluPath.sv
busSelect.sv
controlSequencer.sv
miniSrcCore.sv
coreTb.sv
